/* hw/comp_defs.svh */
`ifndef COMP_DEFS_SVH
`define COMP_DEFS_SVH

// bus widths
`define COMP_DATA_W      32
`define COMP_ADDR_W      16
`define COMP_SEL_W       3

// ram covers 0x0000..0x0fff
`define COMP_MEM_WORDS   4096

// io map, word addresses
`define COMP_PORTO_BASE  16'hff00   // ports a..d at offsets 0..3
`define COMP_PORTJ_ADDR  16'hff10
`define COMP_PORTI_ADDR  16'hff20
`define COMP_TMR_BASE    16'hff30

// timer register offsets
`define COMP_TMR_CTRL    0   // bit 0 en, bit 1 irq en, bit 31 reach flag
`define COMP_TMR_PSC     1
`define COMP_TMR_ARR     2
`define COMP_TMR_CTR     3

`endif

/* hw/comp_pkg.sv */
`default_nettype none

`include "comp_defs.svh"

package comp_pkg;

   // one bus word
   typedef logic [`COMP_DATA_W-1:0] word_t;

   // word address on the cpu bus
   typedef logic [`COMP_ADDR_W-1:0] addr_t;

   // which device answers a pending read
   typedef logic [`COMP_SEL_W-1:0] sel_t;

   localparam sel_t SEL_NONE  = 3'd0;
   localparam sel_t SEL_RAM   = 3'd1;
   localparam sel_t SEL_PORTO = 3'd2;
   localparam sel_t SEL_PORTJ = 3'd3;
   localparam sel_t SEL_PORTI = 3'd4;
   localparam sel_t SEL_TIMER = 3'd5;

endpackage

`default_nettype wire

/* hw/mbus_if.sv */
`default_nettype none

// decoder to device bus, one instance per device
interface mbus_if
   import comp_pkg::*;
();

   logic  cs;     // address in device range, strobe cycle only
   logic  wen;    // already qualified by cs
   logic  ren;    // already qualified by cs
   addr_t addr;   // only the low bits the device decodes
   word_t wdata;
   word_t rdata;  // registered in the device

   modport host (
      output cs,
      output wen,
      output ren,
      output addr,
      output wdata,
      input  rdata
   );

   modport dev (
      input  cs,
      input  wen,
      input  ren,
      input  addr,
      input  wdata,
      output rdata
   );

endinterface

`default_nettype wire

/* hw/addr_dec.sv */
`default_nettype none

`include "comp_defs.svh"

module addr_dec
   import comp_pkg::*;
(
   input  wire   clk,
   input  wire   reset,
   input  wire addr_t addr,
   input  wire word_t wdata,
   input  wire   wen,
   input  wire   ren,
   output word_t rdata,
   output logic  rvalid,
   mbus_if.host  ram_bus,
   mbus_if.host  porto_bus,
   mbus_if.host  portj_bus,
   mbus_if.host  porti_bus,
   mbus_if.host  tmr_bus
);

   localparam int    RAM_AW     = $clog2(`COMP_MEM_WORDS);
   localparam addr_t PORTO_BASE = `COMP_PORTO_BASE;
   localparam addr_t TMR_BASE   = `COMP_TMR_BASE;

   logic       hit_ram, hit_porto, hit_portj, hit_porti, hit_tmr;
   logic       strobe;
   logic [4:0] hits;
   sel_t       sel;
   sel_t       sel_q;

   assign strobe = wen | ren;

   assign hit_ram   = addr < `COMP_MEM_WORDS;
   assign hit_porto = addr[`COMP_ADDR_W-1:2] == PORTO_BASE[`COMP_ADDR_W-1:2];
   assign hit_portj = addr == `COMP_PORTJ_ADDR;
   assign hit_porti = addr == `COMP_PORTI_ADDR;
   assign hit_tmr   = addr[`COMP_ADDR_W-1:2] == TMR_BASE[`COMP_ADDR_W-1:2];
   assign hits      = {hit_tmr, hit_porti, hit_portj, hit_porto, hit_ram};

   always_comb begin
      sel = SEL_NONE;
      if (hit_ram)   sel = SEL_RAM;
      if (hit_porto) sel = SEL_PORTO;
      if (hit_portj) sel = SEL_PORTJ;
      if (hit_porti) sel = SEL_PORTI;
      if (hit_tmr)   sel = SEL_TIMER;
   end

   // ram gets the word index inside its range
   assign ram_bus.cs    = hit_ram & strobe;
   assign ram_bus.wen   = hit_ram & wen;
   assign ram_bus.ren   = hit_ram & ren;
   assign ram_bus.addr  = addr_t'(addr[RAM_AW-1:0]);
   assign ram_bus.wdata = wdata;

   assign porto_bus.cs    = hit_porto & strobe;
   assign porto_bus.wen   = hit_porto & wen;
   assign porto_bus.ren   = hit_porto & ren;
   assign porto_bus.addr  = addr_t'(addr[1:0]);   // port a..d
   assign porto_bus.wdata = wdata;

   assign portj_bus.cs    = hit_portj & strobe;
   assign portj_bus.wen   = hit_portj & wen;
   assign portj_bus.ren   = hit_portj & ren;
   assign portj_bus.addr  = '0;   // single register
   assign portj_bus.wdata = wdata;

   assign porti_bus.cs    = hit_porti & strobe;
   assign porti_bus.wen   = hit_porti & wen;
   assign porti_bus.ren   = hit_porti & ren;
   assign porti_bus.addr  = '0;
   assign porti_bus.wdata = wdata;

   assign tmr_bus.cs    = hit_tmr & strobe;
   assign tmr_bus.wen   = hit_tmr & wen;
   assign tmr_bus.ren   = hit_tmr & ren;
   assign tmr_bus.addr  = addr_t'(addr[1:0]);   // register offset
   assign tmr_bus.wdata = wdata;

   // remember who answers, data comes back next cycle
   always_ff @(posedge clk) begin
      if (reset) begin
         rvalid <= 1'b0;
         sel_q  <= SEL_NONE;
      end else begin
         rvalid <= ren;
         sel_q  <= ren ? sel : SEL_NONE;
      end
   end

   always_comb begin
      case (sel_q)
         SEL_RAM:   rdata = ram_bus.rdata;
         SEL_PORTO: rdata = porto_bus.rdata;
         SEL_PORTJ: rdata = portj_bus.rdata;
         SEL_PORTI: rdata = porti_bus.rdata;
         SEL_TIMER: rdata = tmr_bus.rdata;
         default:   rdata = '0;   // unmapped reads as zero
      endcase
   end

   a_one_select: assert property (@(posedge clk) disable iff (reset) $onehot0(hits));

   // cpu never reads and writes in the same cycle
   a_no_overlap: assert property (@(posedge clk) disable iff (reset) !(wen && ren));

endmodule

`default_nettype wire

/* hw/ram.sv */
`default_nettype none

`include "comp_defs.svh"

module ram
   import comp_pkg::*;
#(
   parameter int DEPTH = `COMP_MEM_WORDS
) (
   input  wire  clk,
   mbus_if.dev  bus
);

   localparam int AW = $clog2(DEPTH);

   word_t        mem [DEPTH];
   logic [AW-1:0] idx;

   assign idx = bus.addr[AW-1:0];

   // write lands at the strobe edge
   always_ff @(posedge clk) begin
      if (bus.cs && bus.wen) begin
         mem[idx] <= bus.wdata;
      end
   end

   // registered read, held until the next read
   always_ff @(posedge clk) begin
      if (bus.cs && bus.ren) begin
         bus.rdata <= mem[idx];
      end
   end

   // decoder must never hand over an index past the array
   a_addr_in_range: assert property (@(posedge clk) bus.cs |-> (bus.addr < DEPTH));

endmodule

`default_nettype wire

/* hw/timer.sv */
`default_nettype none

`include "comp_defs.svh"

module timer
   import comp_pkg::*;
(
   input  wire  clk,
   input  wire  reset,
   mbus_if.dev  bus,
   output logic irq
);

   localparam logic [1:0] OFF_CTRL = 2'(`COMP_TMR_CTRL);
   localparam logic [1:0] OFF_PSC  = 2'(`COMP_TMR_PSC);
   localparam logic [1:0] OFF_ARR  = 2'(`COMP_TMR_ARR);
   localparam logic [1:0] OFF_CTR  = 2'(`COMP_TMR_CTR);

   logic       en;        // counting enabled
   logic       ie;        // interrupt enable
   logic       flag;      // sticky reach flag
   word_t      psc;
   word_t      arr;
   word_t      ctr;
   word_t      psc_cnt;
   logic [1:0] off;
   logic       wr;
   logic       ctr_wr;
   logic       arr_wr;
   logic       flag_clr;
   logic       tick;

   assign off      = bus.addr[1:0];
   assign wr       = bus.cs & bus.wen;
   assign ctr_wr   = wr && (off == OFF_CTR);
   assign arr_wr   = wr && (off == OFF_ARR);
   assign flag_clr = wr && (off == OFF_CTRL) && bus.wdata[31];   // write 1 to clear

   // one counter step every psc+1 clocks
   assign tick = en && (psc_cnt >= psc);

   always_ff @(posedge clk) begin
      if (reset) begin
         en  <= 1'b0;
         ie  <= 1'b0;
         psc <= '0;
         arr <= '0;
      end else if (wr) begin
         case (off)
            OFF_CTRL: begin
               en <= bus.wdata[0];
               ie <= bus.wdata[1];
            end
            OFF_PSC: psc <= bus.wdata;
            OFF_ARR: arr <= bus.wdata;
            default: ;   // counter handled below
         endcase
      end
   end

   always_ff @(posedge clk) begin
      if (reset || !en) begin
         psc_cnt <= '0;
      end else if (tick) begin
         psc_cnt <= '0;
      end else begin
         psc_cnt <= psc_cnt + 1'b1;
      end
   end

   // reload also pulls a counter that sits above arr back to zero
   always_ff @(posedge clk) begin
      if (reset) begin
         ctr  <= '0;
         flag <= 1'b0;
      end else begin
         if (flag_clr) flag <= 1'b0;
         if (ctr_wr) begin
            ctr <= bus.wdata;
         end else if (tick) begin
            if (ctr >= arr) begin
               ctr  <= '0;
               flag <= 1'b1;   // a reach in the same cycle wins over the clear
            end else begin
               ctr <= ctr + 1'b1;
            end
         end
      end
   end

   always_ff @(posedge clk) begin
      if (reset) begin
         irq <= 1'b0;
      end else begin
         irq <= flag & ie;
      end
   end

   always_ff @(posedge clk) begin
      if (bus.cs && bus.ren) begin
         case (off)
            OFF_CTRL: bus.rdata <= {flag, 29'd0, ie, en};
            OFF_PSC:  bus.rdata <= psc;
            OFF_ARR:  bus.rdata <= arr;
            default:  bus.rdata <= ctr;
         endcase
      end
   end

   // only a register write can leave the counter above arr
   a_ctr_le_arr: assert property (@(posedge clk) disable iff (reset)
      $rose(ctr > arr) |-> $past(ctr_wr || arr_wr));

endmodule

`default_nettype wire

/* hw/gpio_in.sv */
`default_nettype none

module gpio_in
   import comp_pkg::*;
(
   input  wire  clk,
   input  wire  reset,
   mbus_if.dev  bus,
   input  wire word_t pins
);

   word_t sync1;   // may go metastable
   word_t sync2;

   // pins are asynchronous to clk
   always_ff @(posedge clk) begin
      if (reset) begin
         sync1 <= '0;
         sync2 <= '0;
      end else begin
         sync1 <= pins;
         sync2 <= sync1;
      end
   end

   // read only port, bus writes fall through
   always_ff @(posedge clk) begin
      if (bus.cs && bus.ren) begin
         bus.rdata <= sync2;
      end
   end

endmodule

`default_nettype wire

/* hw/gpio_out4.sv */
`default_nettype none

module gpio_out4
   import comp_pkg::*;
(
   input  wire   clk,
   input  wire   reset,
   mbus_if.dev   bus,
   output word_t porta,
   output word_t portb,
   output word_t portc,
   output word_t portd
);

   word_t      regs [4];   // a, b, c, d
   logic [1:0] off;

   assign off = bus.addr[1:0];

   always_ff @(posedge clk) begin
      if (reset) begin
         regs[0] <= '0;
         regs[1] <= '0;
         regs[2] <= '0;
         regs[3] <= '0;
      end else if (bus.cs && bus.wen) begin
         regs[off] <= bus.wdata;
      end
   end

   // readback of the latched value
   always_ff @(posedge clk) begin
      if (bus.cs && bus.ren) begin
         bus.rdata <= regs[off];
      end
   end

   assign porta = regs[0];
   assign portb = regs[1];
   assign portc = regs[2];
   assign portd = regs[3];

endmodule

`default_nettype wire

/* hw/comp_io.sv */
`default_nettype none

`include "comp_defs.svh"

module comp_io
   import comp_pkg::*;
(
   input  wire        clk,
   input  wire        reset,
   // cpu bus, word addressed
   input  wire addr_t bus_addr,
   input  wire word_t bus_wdata,
   input  wire        bus_wen,
   input  wire        bus_ren,
   output word_t      bus_rdata,
   output logic       bus_rvalid,
   // ports
   input  wire word_t porti,
   input  wire word_t portj,
   output word_t      porta,
   output word_t      portb,
   output word_t      portc,
   output word_t      portd,
   output logic       irq
);

   mbus_if ram_bus ();
   mbus_if porto_bus ();
   mbus_if portj_bus ();
   mbus_if porti_bus ();
   mbus_if tmr_bus ();

   addr_dec i_addr_dec (
      .clk       (clk),
      .reset     (reset),
      .addr      (bus_addr),
      .wdata     (bus_wdata),
      .wen       (bus_wen),
      .ren       (bus_ren),
      .rdata     (bus_rdata),
      .rvalid    (bus_rvalid),
      .ram_bus   (ram_bus),
      .porto_bus (porto_bus),
      .portj_bus (portj_bus),
      .porti_bus (porti_bus),
      .tmr_bus   (tmr_bus)
   );

   ram #(
      .DEPTH (`COMP_MEM_WORDS)
   ) i_ram (
      .clk (clk),
      .bus (ram_bus)
   );

   gpio_in i_porti (
      .clk   (clk),
      .reset (reset),
      .bus   (porti_bus),
      .pins  (porti)
   );

   gpio_in i_portj (
      .clk   (clk),
      .reset (reset),
      .bus   (portj_bus),
      .pins  (portj)
   );

   gpio_out4 i_gpio_out4 (
      .clk   (clk),
      .reset (reset),
      .bus   (porto_bus),
      .porta (porta),
      .portb (portb),
      .portc (portc),
      .portd (portd)
   );

   // counts clk through its own prescaler
   timer i_timer (
      .clk   (clk),
      .reset (reset),
      .bus   (tmr_bus),
      .irq   (irq)
   );

endmodule

`default_nettype wire

/* dv/tb_comp_io.sv */
`default_nettype none

`include "comp_defs.svh"

module tb_comp_io
   import comp_pkg::*;
();

   timeunit 1ns;
   timeprecision 1ps;

   localparam int    RD_TIMEOUT = 16;    // cycles
   localparam int    POLL_LIMIT = 100;   // ctrl reads
   localparam addr_t TMR_CTRL   = addr_t'(`COMP_TMR_BASE + `COMP_TMR_CTRL);
   localparam addr_t TMR_PSC    = addr_t'(`COMP_TMR_BASE + `COMP_TMR_PSC);
   localparam addr_t TMR_ARR    = addr_t'(`COMP_TMR_BASE + `COMP_TMR_ARR);
   localparam addr_t TMR_CTR    = addr_t'(`COMP_TMR_BASE + `COMP_TMR_CTR);

   logic        clk;
   logic        reset;
   addr_t       bus_addr;
   word_t       bus_wdata;
   logic        bus_wen;
   logic        bus_ren;
   word_t       bus_rdata;
   logic        bus_rvalid;
   word_t       porti;
   word_t       portj;
   word_t       porta;
   word_t       portb;
   word_t       portc;
   word_t       portd;
   logic        irq;
   logic [31:0] lfsr_state;
   word_t       port_vals [4];   // values written to ports a..d

   comp_io i_comp_io (
      .clk        (clk),
      .reset      (reset),
      .bus_addr   (bus_addr),
      .bus_wdata  (bus_wdata),
      .bus_wen    (bus_wen),
      .bus_ren    (bus_ren),
      .bus_rdata  (bus_rdata),
      .bus_rvalid (bus_rvalid),
      .porti      (porti),
      .portj      (portj),
      .porta      (porta),
      .portb      (portb),
      .portc      (portc),
      .portd      (portd),
      .irq        (irq)
   );

   initial clk = 1'b0;
   always #20 clk = ~clk;   // 40 ns period

   // x^32 + x^22 + x^2 + x + 1
   function automatic logic [31:0] lfsr_next(input logic [31:0] s);
      return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
   endfunction

   function automatic word_t rand_bits(input int n);
      word_t v;
      v = '0;
      for (int i = 0; i < n; i++) begin
         lfsr_state = lfsr_next(lfsr_state);   // one step per bit
         v = {v[30:0], lfsr_state[0]};
      end
      return v;
   endfunction

   function automatic word_t port_out(input int i);
      case (i)
         0: return porta;
         1: return portb;
         2: return portc;
         default: return portd;
      endcase
   endfunction

   task automatic abort_run(input string why);
      $display("%s at %0d ns", why, $time);
      $display("=== FAIL ===");
      $fatal(1, "simulation stopped");
   endtask

   task automatic check_word(input string name, input word_t got, input word_t exp);
      if (got !== exp) begin
         $display("error at %0d ns: %s = %h, expected %h", $time, name, got, exp);
         $display("=== FAIL ===");
         $fatal(1, "value mismatch");
      end
   endtask

   task automatic check_bit(input string name, input logic got, input logic exp);
      if (got !== exp) begin
         $display("error at %0d ns: %s = %b, expected %b", $time, name, got, exp);
         $display("=== FAIL ===");
         $fatal(1, "value mismatch");
      end
   endtask

   task automatic check_at_most(input string name, input word_t got, input word_t limit);
      if ($isunknown(got) || got > limit) begin
         $display("error at %0d ns: %s = %h, expected at most %h", $time, name, got, limit);
         $display("=== FAIL ===");
         $fatal(1, "value out of range");
      end
   endtask

   // inputs change 2 ns after the rising edge
   task automatic next_cycle();
      @(posedge clk);
      #2;
   endtask

   task automatic apply_reset();
      reset = 1'b1;
      repeat (5) next_cycle();
      reset = 1'b0;
   endtask

   task automatic bus_write(input addr_t addr, input word_t data);
      bus_addr  = addr;
      bus_wdata = data;
      bus_wen   = 1'b1;
      next_cycle();
      bus_wen   = 1'b0;
   endtask

   task automatic bus_read(input addr_t addr, output word_t data);
      int waited = 0;
      bus_addr = addr;
      bus_ren  = 1'b1;
      next_cycle();
      bus_ren  = 1'b0;
      while (bus_rvalid !== 1'b1) begin
         if (waited == RD_TIMEOUT) abort_run("timeout waiting for bus_rvalid");
         next_cycle();
         waited++;
      end
      data = bus_rdata;
   endtask

   task automatic read_check(input addr_t addr, input word_t exp, input string name);
      word_t got;
      bus_read(addr, got);
      check_word(name, got, exp);
   endtask

   task automatic check_reset_state();
      check_word("porta", porta, '0);
      check_word("portb", portb, '0);
      check_word("portc", portc, '0);
      check_word("portd", portd, '0);
      check_bit("irq", irq, 1'b0);
      check_bit("bus_rvalid", bus_rvalid, 1'b0);
   endtask

   task automatic ram_test();
      word_t model [addr_t];
      addr_t addrs [$];
      addr_t a;
      word_t d;
      for (int i = 0; i < 32; i++) begin
         a = addr_t'(rand_bits(12));   // below 4096 words
         d = rand_bits(32);
         bus_write(a, d);
         model[a] = d;
         addrs.push_back(a);
      end
      foreach (addrs[i]) read_check(addrs[i], model[addrs[i]], "bus_rdata");
      // each back to back strobe answers one cycle later
      foreach (addrs[i]) begin
         bus_addr = addrs[i];
         bus_ren  = 1'b1;
         next_cycle();
         check_bit("bus_rvalid", bus_rvalid, 1'b1);
         check_word("bus_rdata", bus_rdata, model[addrs[i]]);
      end
      bus_ren = 1'b0;
      next_cycle();
      check_bit("bus_rvalid", bus_rvalid, 1'b0);
   endtask

   task automatic ports_out_test();
      string names [4];
      names = '{"porta", "portb", "portc", "portd"};
      for (int i = 0; i < 4; i++) begin
         port_vals[i] = rand_bits(28) | (word_t'(i + 1) << 28);   // distinct top nibble
         bus_write(addr_t'(`COMP_PORTO_BASE + i), port_vals[i]);
         check_word(names[i], port_out(i), port_vals[i]);
      end
      for (int i = 0; i < 4; i++) begin
         read_check(addr_t'(`COMP_PORTO_BASE + i), port_vals[i], "bus_rdata");
      end
   endtask

   task automatic ports_in_test();
      word_t vi;
      word_t vj;
      vi = rand_bits(32);
      vj = rand_bits(32);
      porti = vi;
      portj = vj;
      repeat (3) next_cycle();   // past both sync flops
      read_check(addr_t'(`COMP_PORTI_ADDR), vi, "bus_rdata");
      read_check(addr_t'(`COMP_PORTJ_ADDR), vj, "bus_rdata");
      bus_write(addr_t'(`COMP_PORTI_ADDR), ~vi);
      bus_write(addr_t'(`COMP_PORTJ_ADDR), ~vj);
      read_check(addr_t'(`COMP_PORTI_ADDR), vi, "bus_rdata");
      read_check(addr_t'(`COMP_PORTJ_ADDR), vj, "bus_rdata");
      for (int i = 0; i < 4; i++) check_word("output port", port_out(i), port_vals[i]);
   endtask

   task automatic timer_reach_test();
      word_t ctrl;
      int polls = 0;
      bus_write(TMR_PSC, 32'd2);
      bus_write(TMR_ARR, 32'd5);
      bus_write(TMR_CTRL, 32'h3);   // enable plus interrupt enable
      check_bit("irq", irq, 1'b0);
      bus_read(TMR_CTRL, ctrl);
      while (!ctrl[31]) begin
         if (polls == POLL_LIMIT) abort_run("timer reach flag never set");
         polls++;
         bus_read(TMR_CTRL, ctrl);
      end
      check_word("timer ctrl", ctrl, 32'h8000_0003);
      check_bit("irq", irq, 1'b1);
      // stop counting so no new reach lands on the clear
      bus_write(TMR_CTRL, 32'h2);
      bus_write(TMR_CTRL, 32'h8000_0002);
      next_cycle();   // irq trails the flag by one register
      check_bit("irq", irq, 1'b0);
      read_check(TMR_CTRL, 32'h2, "timer ctrl");
   endtask

   task automatic timer_hold_test();
      word_t got;
      bus_write(TMR_CTRL, 32'h0);
      bus_write(TMR_CTR, 32'h0000_1234);
      read_check(TMR_CTR, 32'h0000_1234, "timer ctr");
      repeat (4) next_cycle();
      read_check(TMR_CTR, 32'h0000_1234, "timer ctr");
      bus_write(TMR_ARR, 32'd7);
      bus_write(TMR_PSC, 32'd0);
      bus_write(TMR_CTR, 32'd0);
      bus_write(TMR_CTRL, 32'h1);
      for (int i = 0; i < 24; i++) begin
         bus_read(TMR_CTR, got);
         check_at_most("timer ctr", got, 32'd7);
      end
      bus_write(TMR_CTRL, 32'h0);
   endtask

   task automatic unmapped_test();
      read_check(16'h8000, '0, "bus_rdata");
      bus_write(16'h8000, 32'hdead_beef);
      read_check(16'h8000, '0, "bus_rdata");
      read_check(16'hff04, '0, "bus_rdata");   // gap after port d
   endtask

   initial begin
      lfsr_state = 32'h329f;
      reset      = 1'b1;
      bus_addr   = '0;
      bus_wdata  = '0;
      bus_wen    = 1'b0;
      bus_ren    = 1'b0;
      porti      = '0;
      portj      = '0;
      apply_reset();
      check_reset_state();
      ram_test();
      ports_out_test();
      ports_in_test();
      timer_reach_test();
      timer_hold_test();
      unmapped_test();
      // flag still set from the timer run, irq enable alone raises irq
      bus_write(TMR_CTRL, 32'h2);
      next_cycle();
      check_bit("irq", irq, 1'b1);
      // reset must clear the written ports and the raised irq
      apply_reset();
      check_reset_state();
      read_check(TMR_CTRL, '0, "timer ctrl");
      read_check(TMR_CTR, '0, "timer ctr");
      $display("=== PASS ===");
      $finish;
   end

endmodule

`default_nettype wire

/* verilog.f */
+incdir+hw
hw/comp_pkg.sv
hw/mbus_if.sv
hw/addr_dec.sv
hw/ram.sv
hw/timer.sv
hw/gpio_in.sv
hw/gpio_out4.sv
hw/comp_io.sv
dv/tb_comp_io.sv

/* run_sim.sh */
#!/bin/sh
# build and run tb_comp_io with verilator, then judge the run from its log
set -e

cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal \
   -f verilog.f --top-module tb_comp_io -o tb_comp_io

# a failing run exits nonzero, the log decides below
./obj_dir/tb_comp_io > sim.log 2>&1 || true
cat sim.log

if grep -q "=== FAIL ===" sim.log; then
   echo "simulation failed"
   exit 1
fi
if ! grep -q "=== PASS ===" sim.log; then
   echo "simulation ended without a result"
   exit 1
fi
echo "simulation passed"
